/* scene_input.txt */
// hex words; 1 stage head1 head2 apple power hearts inv swap | 2 snake idx tile
// 3 x y rgb (probe, raster order) | f end; unlisted body tiles are off-board filler
// board objects, meters and sidebar
1 2 d3 3ed 5dc 19f 32 19 0
2 1 0 d2
2 1 1 d3
2 2 0 33e
2 2 1 33f
3 7d 41 43a047
3 89 41 fdd835
3 1f4 46 9e9e9e
3 22f 46 000000
3 230 46 9e9e9e
3 21b 6e 0000ff
3 21c 6e 9e9e9e
3 5 7d 2e7d32
3 b9 7d 8e24aa
3 16d f5 1e88e5
3 41 131 fdd835
3 26c 190 9e9e9e
3 f5 1c1 e53935
// priority: head over body2, body2 over body1, apple over head
1 2 12c 26c 26c 4b0 0 0 0
2 1 0 12d
2 2 0 12c
2 2 1 12d
3 209 46 9e9e9e
3 f5 59 fdd835
3 101 59 1e88e5
3 f5 b9 e53935
3 5 16d 8e24aa
// title stage, all black
1 0 d3 3ed 5dc 19f 32 19 0
2 1 0 d2
3 7d 41 000000
3 22f 46 000000
3 5 7d 000000
3 26c 190 000000
// capture: old scene holds for the rest of its frame
1 2 640 640 3e8 641 0 0 0
3 5 131 e53935
3 f5 1c1 2e7d32
// swapped in mid frame, shows one frame later
1 2 640 640 5dc 641 0 0 1
3 5 131 2e7d32
3 f5 1c1 e53935
f

/* filelist.f */
vga_timing_pkg.sv
snake_scene_pkg.sv
video_sync_generator.sv
board_locator.sv
target_find.sv
tile_painter.sv
palette_out.sv
vga_controller.sv
tb_clock_gen.sv
tb_vga_controller.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_vga_controller -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -qx "sim passed" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

/* tb_vga_controller.sv */
module tb_vga_controller;

	import vga_timing_pkg::*;
	import snake_scene_pkg::*;

	localparam int WORDS     = 256;
	localparam int FRAME_PIX = H_ACTIVE * V_ACTIVE;
	localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
	// pixel count where a swapped scene goes onto the input
	localparam int SWAP_PIX  = H_ACTIVE * 200;

	// one probed pixel and the colour it should have
	typedef struct packed {
		logic [X_W-1:0] x;
		logic [Y_W-1:0] y;
		rgb_t           colour;
	} probe_t;

	logic   iVGA_CLK;
	logic   iRST_n;
	scene_t scene;
	logic   hs;
	logic   vs;
	logic   blank_n;
	rgb_t   rgb;

	// raw words from the input file, then the decoded records
	logic [23:0] words [WORDS];
	scene_t      scenes [$];
	logic        swaps [$];
	int          first_probe [$];
	probe_t      probes [$];
	int          seed;

	tb_clock_gen u_clk (
		.iVGA_CLK (iVGA_CLK),
		.iRST_n   (iRST_n)
	);

	vga_controller dut (
		.iVGA_CLK (iVGA_CLK),
		.iRST_n   (iRST_n),
		.scene    (scene),
		.hs       (hs),
		.vs       (vs),
		.blank_n  (blank_n),
		.rgb      (rgb)
	);

	////////////////////////////////////////////////////////////
	// reporting and compare
	////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
		if (actual !== expected)
			abort_run($sformatf("Mismatch %s: expected %06h, actual %06h", name, expected, actual));
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual !== expected)
			abort_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	task automatic check_level(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("Mismatch %s: expected %b, actual %b", name, expected, actual));
	endtask

	// outputs settle on the edge, inputs move just after it
	task automatic next_cycle();
		@(posedge iVGA_CLK);
		#1;
	endtask

	task automatic wait_reset_release();
		int guard;
		guard = 0;
		while (!iRST_n) begin
			guard++;
			if (guard > 16)
				abort_run("timeout: reset was never released");
			next_cycle();
		end
	endtask

	task automatic wait_vs_fall();
		logic vs_q;
		int   guard;
		vs_q  = vs;
		guard = 0;
		next_cycle();
		while (!(vs_q && !vs)) begin
			guard++;
			if (guard > FRAME_CYC + H_TOTAL)
				abort_run("timeout: vs never fell");
			vs_q = vs;
			next_cycle();
		end
	endtask

	// filler tiles sit above the board range, never drawn
	function automatic tile_num_t filler_tile();
		int r;
		r = $random(seed);
		return tile_num_t'(1600 + ((r & 32'h7fff_ffff) % 448));
	endfunction

	////////////////////////////////////////////////////////////
	// input file decode
	////////////////////////////////////////////////////////////

	task automatic load_input();
		int     pos;
		int     k;
		logic   done;
		scene_t sc;
		probe_t pr;
		for (k = 0; k < WORDS; k++)
			words[k] = '1;
		$readmemh("scene_input.txt", words);
		pos  = 0;
		done = 1'b0;
		while (!done) begin
			if (pos > WORDS - 9)
				abort_run("input file has no end record");
			case (words[pos])
				24'h1: begin
					sc              = '0;
					sc.stage        = stage_e'(words[pos+1][1:0]);
					sc.head1        = words[pos+2][TILE_W-1:0];
					sc.head2        = words[pos+3][TILE_W-1:0];
					sc.apple        = words[pos+4][TILE_W-1:0];
					sc.power        = words[pos+5][TILE_W-1:0];
					sc.hearts_timer = words[pos+6][TIMER_W-1:0];
					sc.inv_timer    = words[pos+7][TIMER_W-1:0];
					for (k = 0; k < BODY_LEN; k++) begin
						sc.body1[k] = filler_tile();
						sc.body2[k] = filler_tile();
					end
					scenes.push_back(sc);
					swaps.push_back(words[pos+8][0]);
					first_probe.push_back(probes.size());
					pos += 9;
				end
				24'h2: begin
					k = int'(words[pos+2]);
					if ((scenes.size() == 0) || (k >= BODY_LEN))
						abort_run($sformatf("bad body record at word %0d", pos));
					sc = scenes[scenes.size()-1];
					if (words[pos+1] == 24'h1)
						sc.body1[k] = words[pos+3][TILE_W-1:0];
					else
						sc.body2[k] = words[pos+3][TILE_W-1:0];
					scenes[scenes.size()-1] = sc;
					pos += 4;
				end
				24'h3: begin
					pr.x      = words[pos+1][X_W-1:0];
					pr.y      = words[pos+2][Y_W-1:0];
					pr.colour = rgb_t'(words[pos+3]);
					probes.push_back(pr);
					pos += 4;
				end
				24'hf: done = 1'b1;
				default: abort_run($sformatf("bad record tag %0h at word %0d", words[pos], pos));
			endcase
		end
		if ((scenes.size() == 0) || swaps[0])
			abort_run("input file has no usable first scene");
	endtask

	////////////////////////////////////////////////////////////
	// frame checks
	////////////////////////////////////////////////////////////

	// line widths, hs pulse and line count over one frame
	task automatic measure_frame();
		int   pix;
		int   hs_low;
		int   lines;
		int   guard;
		logic blank_q;
		logic hs_q;
		logic vs_q;
		logic done;
		wait_vs_fall();
		pix     = 0;
		hs_low  = 0;
		lines   = 0;
		guard   = 0;
		blank_q = blank_n;
		hs_q    = hs;
		vs_q    = vs;
		done    = 1'b0;
		while (!done) begin
			next_cycle();
			guard++;
			if (guard > FRAME_CYC + H_TOTAL)
				abort_run("timeout: vs did not fall again while measuring a frame");
			if (blank_n)
				pix++;
			if (!hs)
				hs_low++;
			// end of a visible line
			if (blank_q && !blank_n) begin
				check_count("pixels per line", 640, pix);
				pix = 0;
				lines++;
			end
			if (!hs_q && hs) begin
				check_count("hs low cycles per line", 96, hs_low);
				hs_low = 0;
			end
			done    = vs_q && !vs;
			blank_q = blank_n;
			hs_q    = hs;
			vs_q    = vs;
		end
		check_count("active lines per frame", 480, lines);
	endtask

	// walk the visible pixels, probes come in raster order
	task automatic check_frame(input int idx);
		int     n;
		int     p;
		int     p_end;
		int     guard;
		int     x;
		int     y;
		logic   swap_next;
		probe_t pr;
		n         = 0;
		guard     = 0;
		p         = first_probe[idx];
		p_end     = (idx + 1 < scenes.size()) ? first_probe[idx+1] : probes.size();
		swap_next = (idx + 1 < scenes.size()) && swaps[idx+1];
		while (n < FRAME_PIX) begin
			next_cycle();
			guard++;
			if (guard > FRAME_CYC)
				abort_run($sformatf("timeout: scene %0d frame has too few visible pixels", idx));
			if (blank_n) begin
				x = n % 640;
				y = n / 640;
				if (p < p_end) begin
					pr = probes[p];
					if ((int'(pr.x) == x) && (int'(pr.y) == y)) begin
						check_rgb($sformatf("scene %0d pixel %0d,%0d", idx, x, y), pr.colour, rgb);
						p++;
					end
				end
				n++;
				// new scene lands mid frame, after capture
				if (swap_next && (n == SWAP_PIX))
					scene = scenes[idx+1];
			end
		end
		if (p != p_end)
			abort_run($sformatf("scene %0d probe %0d never reached, off screen or out of order",
				idx, p));
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int idx;
		scene = '0;
		seed  = 32'h414f_1cc7;
		load_input();
		// first edge with reset still held
		next_cycle();
		check_level("hs during reset", 1'b1, hs);
		check_level("vs during reset", 1'b1, vs);
		check_level("blank_n during reset", 1'b0, blank_n);
		check_rgb("rgb during reset", '0, rgb);
		wait_reset_release();
		measure_frame();
		for (idx = 0; idx < scenes.size(); idx++) begin
			// a swapped scene is already on the input
			if (!swaps[idx])
				scene = scenes[idx];
			wait_vs_fall();
			check_frame(idx);
		end
		$display("sim passed");
		$finish;
	end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
	output logic iVGA_CLK,
	output logic iRST_n
);

	// period 4
	initial begin
		iVGA_CLK = 1'b0;
		forever #2 iVGA_CLK = ~iVGA_CLK;
	end

	// reset held over the first two rising edges
	initial begin
		iRST_n = 1'b0;
		repeat (2) @(posedge iVGA_CLK);
		#1;
		iRST_n = 1'b1;
	end

endmodule

/* vga_controller.sv */
module vga_controller (
	input  logic                    iVGA_CLK,
	input  logic                    iRST_n,
	input  snake_scene_pkg::scene_t scene,
	output logic                    hs,
	output logic                    vs,
	output logic                    blank_n,
	output snake_scene_pkg::rgb_t   rgb
);

	import vga_timing_pkg::*;
	import snake_scene_pkg::*;

	// pipe: counters, tile decode, class, colour
	pixel_pos_t  pos;
	tile_loc_t   loc;
	tile_class_e tile_class;
	pixel_pos_t  pos_d;

	video_sync_generator u_sync (
		.iVGA_CLK (iVGA_CLK),
		.iRST_n   (iRST_n),
		.pos      (pos)
	);

	board_locator u_locator (
		.iVGA_CLK (iVGA_CLK),
		.iRST_n   (iRST_n),
		.pos      (pos),
		.loc      (loc)
	);

	tile_painter u_painter (
		.iVGA_CLK   (iVGA_CLK),
		.iRST_n     (iRST_n),
		.loc        (loc),
		.scene      (scene),
		.tile_class (tile_class),
		.pos_d      (pos_d)
	);

	palette_out u_palette (
		.iVGA_CLK   (iVGA_CLK),
		.iRST_n     (iRST_n),
		.tile_class (tile_class),
		.pos_d      (pos_d),
		.hs         (hs),
		.vs         (vs),
		.blank_n    (blank_n),
		.rgb        (rgb)
	);

endmodule

/* palette_out.sv */
module palette_out (
	input  logic                         iVGA_CLK,
	input  logic                         iRST_n,
	input  snake_scene_pkg::tile_class_e tile_class,
	input  vga_timing_pkg::pixel_pos_t   pos_d,
	output logic                         hs,
	output logic                         vs,
	output logic                         blank_n,
	output snake_scene_pkg::rgb_t        rgb
);

	import snake_scene_pkg::*;

	// colour before the output register
	rgb_t rgb_nxt;

	////////////////////////////////////////////////////////////
	// palette lookup
	////////////////////////////////////////////////////////////

	always_comb begin
		// black in porches and sync
		if (pos_d.active) begin
			rgb_nxt = PALETTE[tile_class];
		end else begin
			rgb_nxt = '0;
		end
	end

	// sync and colour from one register so they stay aligned
	always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
		if (!iRST_n) begin
			hs      <= 1'b1;
			vs      <= 1'b1;
			blank_n <= 1'b0;
			rgb     <= '0;
		end else begin
			hs      <= pos_d.hs;
			vs      <= pos_d.vs;
			// blank_n high only on visible pixels
			blank_n <= pos_d.active;
			rgb     <= rgb_nxt;
		end
	end

endmodule

/* tile_painter.sv */
module tile_painter (
	input  logic                        iVGA_CLK,
	input  logic                        iRST_n,
	input  snake_scene_pkg::tile_loc_t  loc,
	input  snake_scene_pkg::scene_t     scene,
	output snake_scene_pkg::tile_class_e tile_class,
	output vga_timing_pkg::pixel_pos_t  pos_d
);

	import snake_scene_pkg::*;

	scene_t             scene_q;
	logic               vs_q;
	logic               hit1;
	logic               hit2;
	logic [TIMER_W-1:0] timer;
	logic [FILL_W-1:0]  col_scaled;
	logic [FILL_W-1:0]  fill_edge;
	logic               fill;
	tile_class_e        cls_nxt;

	////////////////////////////////////////////////////////////
	// scene capture, once per frame
	////////////////////////////////////////////////////////////

	always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
		if (!iRST_n) begin
			// stage 0 is title, so the screen stays black until a capture
			scene_q <= '0;
			vs_q    <= 1'b1;
		end else begin
			vs_q <= loc.vs;
			// first cycle of vertical sync
			if (vs_q && !loc.vs) begin
				scene_q <= scene;
			end
		end
	end

	// body lookups
	target_find #(.LEN(BODY_LEN)) u_find_body1 (
		.values  (scene_q.body1),
		.target  (loc.tile),
		.present (hit1)
	);

	target_find #(.LEN(BODY_LEN)) u_find_body2 (
		.values  (scene_q.body2),
		.target  (loc.tile),
		.present (hit2)
	);

	// meter fill, x*100 < span*timer + x0*100
	assign timer      = loc.in_heart_meter ? scene_q.hearts_timer : scene_q.inv_timer;
	assign col_scaled = FILL_W'(loc.x) * FILL_W'(METER_FULL);
	assign fill_edge  = FILL_W'(METER_X1 - METER_X0) * FILL_W'(timer) +
		FILL_W'(METER_X0 * METER_FULL);
	assign fill       = col_scaled < fill_edge;

	////////////////////////////////////////////////////////////
	// class select, later checks win
	////////////////////////////////////////////////////////////

	always_comb begin
		cls_nxt = TC_BLACK;
		if (loc.active && (scene_q.stage == ST_GAME)) begin
			if (loc.in_board) begin
				cls_nxt = TC_BOARD;
				if (hit1)
					cls_nxt = TC_BODY1;
				if (hit2)
					cls_nxt = TC_BODY2;
				// both heads share one colour
				if ((loc.tile == scene_q.head1) || (loc.tile == scene_q.head2))
					cls_nxt = TC_HEAD;
				if (loc.tile == scene_q.apple)
					cls_nxt = TC_APPLE;
				if (loc.tile == scene_q.power)
					cls_nxt = TC_POWER;
			end else if (loc.in_heart_meter) begin
				cls_nxt = fill ? TC_HEART_FILL : TC_METER_EMPTY;
			end else if (loc.in_inv_meter) begin
				cls_nxt = fill ? TC_INV_FILL : TC_METER_EMPTY;
			end else begin
				cls_nxt = TC_SIDEBAR;
			end
		end
	end

	// class and position leave together
	always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
		if (!iRST_n) begin
			tile_class   <= TC_BLACK;
			pos_d.x      <= '0;
			pos_d.y      <= '0;
			pos_d.active <= 1'b0;
			pos_d.hs     <= 1'b1;
			pos_d.vs     <= 1'b1;
		end else begin
			tile_class   <= cls_nxt;
			pos_d.x      <= loc.x;
			pos_d.y      <= loc.y;
			pos_d.active <= loc.active;
			pos_d.hs     <= loc.hs;
			pos_d.vs     <= loc.vs;
		end
	end

endmodule

/* target_find.sv */
module target_find #(
	parameter int LEN = snake_scene_pkg::BODY_LEN
) (
	input  logic [LEN-1:0][snake_scene_pkg::TILE_W-1:0] values,
	input  snake_scene_pkg::tile_num_t                  target,
	output logic                                        present
);

	// one match line per body entry
	logic [LEN-1:0] hit;

	genvar i;
	generate
		for (i = 0; i < LEN; i++) begin : g_cmp
			// equal when no bit differs
			assign hit[i] = ~|(values[i] ^ target);
		end
	endgenerate

	// any entry on this tile
	assign present = |hit;

endmodule

/* board_locator.sv */
module board_locator (
	input  logic                       iVGA_CLK,
	input  logic                       iRST_n,
	input  vga_timing_pkg::pixel_pos_t pos,
	output snake_scene_pkg::tile_loc_t loc
);

	import vga_timing_pkg::*;
	import snake_scene_pkg::*;

	// state of the previous pixel
	logic [SUB_W-1:0]  col_sub_q;
	logic [SUB_W-1:0]  row_sub_q;
	logic [TILE_W-1:0] col_q;
	logic [TILE_W-1:0] row_base_q;
	// same, for the pixel now in pos
	logic [SUB_W-1:0]  col_sub_cur;
	logic [SUB_W-1:0]  row_sub_cur;
	logic [TILE_W-1:0] col_cur;
	logic [TILE_W-1:0] row_base_cur;
	logic              meter_x;

	////////////////////////////////////////////////////////////
	// tile stepping, no divider
	////////////////////////////////////////////////////////////

	always_comb begin
		// column, restarts at x 0
		if (pos.x == '0) begin
			col_sub_cur = '0;
			col_cur     = '0;
		end else if (col_sub_q == SUB_W'(TILE_PX - 1)) begin
			col_sub_cur = '0;
			col_cur     = col_q + 1'b1;
		end else begin
			col_sub_cur = col_sub_q + 1'b1;
			col_cur     = col_q;
		end
		// row only moves on the first pixel of a line
		row_sub_cur  = row_sub_q;
		row_base_cur = row_base_q;
		if (pos.x == '0) begin
			if (pos.y == '0) begin
				row_sub_cur  = '0;
				row_base_cur = '0;
			end else if (row_sub_q == SUB_W'(TILE_PX - 1)) begin
				row_sub_cur  = '0;
				// next tile row is 40 tile numbers on
				row_base_cur = row_base_q + TILE_W'(BOARD_TILES);
			end else begin
				row_sub_cur = row_sub_q + 1'b1;
			end
		end
	end

	assign meter_x = (pos.x > X_W'(METER_X0)) && (pos.x < X_W'(METER_X1));

	always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
		if (!iRST_n) begin
			col_sub_q  <= '0;
			row_sub_q  <= '0;
			col_q      <= '0;
			row_base_q <= '0;
			loc        <= '0;
			loc.hs     <= 1'b1;
			loc.vs     <= 1'b1;
		end else begin
			col_sub_q          <= col_sub_cur;
			row_sub_q          <= row_sub_cur;
			col_q              <= col_cur;
			row_base_q         <= row_base_cur;
			loc.tile           <= row_base_cur + col_cur;
			// board is the left 480 columns of the visible lines
			loc.in_board       <= (pos.x < X_W'(BOARD_PX)) && (pos.y < Y_W'(BOARD_PX));
			loc.in_heart_meter <= meter_x && (pos.y > Y_W'(HEART_Y0)) &&
				(pos.y < Y_W'(HEART_Y1));
			loc.in_inv_meter   <= meter_x && (pos.y > Y_W'(INV_Y0)) && (pos.y < Y_W'(INV_Y1));
			loc.x              <= pos.x;
			loc.y              <= pos.y;
			loc.active         <= pos.active;
			loc.hs             <= pos.hs;
			loc.vs             <= pos.vs;
		end
	end

endmodule

/* video_sync_generator.sv */
module video_sync_generator (
	input  logic                       iVGA_CLK,
	input  logic                       iRST_n,
	output vga_timing_pkg::pixel_pos_t pos
);

	import vga_timing_pkg::*;

	// next raster position
	logic [X_W-1:0] x_nxt;
	logic [Y_W-1:0] y_nxt;
	logic           act_nxt;
	logic           hs_nxt;
	logic           vs_nxt;

	////////////////////////////////////////////////////////////
	// counters
	////////////////////////////////////////////////////////////

	always_comb begin
		x_nxt = pos.x + 1'b1;
		y_nxt = pos.y;
		// end of line, step to next line
		if (pos.x == X_W'(H_TOTAL - 1)) begin
			x_nxt = '0;
			if (pos.y == Y_W'(V_TOTAL - 1)) begin
				y_nxt = '0;
			end else begin
				y_nxt = pos.y + 1'b1;
			end
		end
	end

	// decode from the next count so flags line up with x and y
	always_comb begin
		act_nxt = (x_nxt < X_W'(H_ACTIVE)) && (y_nxt < Y_W'(V_ACTIVE));
		// low pulses after the front porch
		hs_nxt  = !((x_nxt >= X_W'(HS_START)) && (x_nxt < X_W'(HS_END)));
		vs_nxt  = !((y_nxt >= Y_W'(VS_START)) && (y_nxt < Y_W'(VS_END)));
	end

	always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
		if (!iRST_n) begin
			// restart at pixel 0,0 which is visible
			pos.x      <= '0;
			pos.y      <= '0;
			pos.active <= 1'b1;
			pos.hs     <= 1'b1;
			pos.vs     <= 1'b1;
		end else begin
			pos.x      <= x_nxt;
			pos.y      <= y_nxt;
			pos.active <= act_nxt;
			pos.hs     <= hs_nxt;
			pos.vs     <= vs_nxt;
		end
	end

endmodule

/* snake_scene_pkg.sv */
package snake_scene_pkg;

	////////////////////////////////////////////////////////////
	// board geometry and sidebar meters
	////////////////////////////////////////////////////////////

	localparam int TILE_PX     = 12;
	localparam int SUB_W       = 4;
	localparam int BOARD_TILES = 40;
	localparam int BOARD_PX    = 480;
	localparam int TILE_W      = 11;
	localparam int BODY_LEN    = 10;

	// meter bounds, all exclusive
	localparam int METER_X0 = 520;
	localparam int METER_X1 = 600;
	localparam int HEART_Y0 = 60;
	localparam int HEART_Y1 = 80;
	localparam int INV_Y0   = 100;
	localparam int INV_Y1   = 120;

	// timers run 0..100, fill compare needs 17 bits
	localparam int TIMER_W    = 7;
	localparam int METER_FULL = 100;
	localparam int FILL_W     = 17;

	typedef enum logic [1:0] {
		ST_TITLE     = 2'd0,
		ST_MENU      = 2'd1,
		ST_GAME      = 2'd2,
		ST_HIGHSCORE = 2'd3
	} stage_e;

	typedef enum logic [3:0] {
		TC_BOARD, TC_BODY1, TC_BODY2, TC_HEAD, TC_APPLE, TC_POWER,
		TC_HEART_FILL, TC_INV_FILL, TC_METER_EMPTY, TC_SIDEBAR, TC_BLACK
	} tile_class_e;

	typedef logic [TILE_W-1:0] tile_num_t;
	typedef logic [BODY_LEN-1:0][TILE_W-1:0] body_list_t;

	// everything the painter needs for one frame
	typedef struct packed {
		stage_e             stage;
		tile_num_t          head1;
		tile_num_t          head2;
		tile_num_t          apple;
		tile_num_t          power;
		body_list_t         body1;
		body_list_t         body2;
		logic [TIMER_W-1:0] hearts_timer;
		logic [TIMER_W-1:0] inv_timer;
	} scene_t;

	// position plus tile decode
	typedef struct packed {
		tile_num_t                      tile;
		logic                           in_board;
		logic                           in_heart_meter;
		logic                           in_inv_meter;
		logic [vga_timing_pkg::X_W-1:0] x;
		logic [vga_timing_pkg::Y_W-1:0] y;
		logic                           active;
		logic                           hs;
		logic                           vs;
	} tile_loc_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// flat colour per class, indexed in enum order
	localparam rgb_t PALETTE [11] = '{
		rgb_t'(24'h2e7d32),
		rgb_t'(24'h43a047),
		rgb_t'(24'h1e88e5),
		rgb_t'(24'hfdd835),
		rgb_t'(24'he53935),
		rgb_t'(24'h8e24aa),
		rgb_t'(24'h000000),
		rgb_t'(24'h0000ff),
		rgb_t'(24'h9e9e9e),
		rgb_t'(24'h9e9e9e),
		rgb_t'(24'h000000)
	};

endpackage

/* vga_timing_pkg.sv */
package vga_timing_pkg;

	////////////////////////////////////////////////////////////
	// 640x480 raster, negative sync polarity
	////////////////////////////////////////////////////////////

	// horizontal, in pixels
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BACK   = 48;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	// vertical, in lines
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 33;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// sync windows, start inclusive, end exclusive
	localparam int HS_START = H_ACTIVE + H_FRONT;
	localparam int HS_END   = HS_START + H_SYNC;
	localparam int VS_START = V_ACTIVE + V_FRONT;
	localparam int VS_END   = VS_START + V_SYNC;

	// coordinate widths
	localparam int X_W = 10;
	localparam int Y_W = 10;

	// one pixel slot as it moves down the pipe
	typedef struct packed {
		logic [X_W-1:0] x;
		logic [Y_W-1:0] y;
		logic           active;
		logic           hs;
		logic           vs;
	} pixel_pos_t;

endpackage
